//--- vlog.f
+incdir+common
common/u2_pkg.sv
logic/setting_reg.sv
logic/misc_ctrl.sv
timekeeper/time_64bit.sv
logic/readback_mux.sv
logic/u2_ctrl_top.sv
verif/tb_u2_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the control slice testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_u2_ctrl \
   && ./obj_dir/Vtb_u2_ctrl > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "Testbench passed" sim.log \
   && echo "Simulation result: PASS" \
   || { echo "Simulation result: FAIL"; exit 1; }

//--- verif/tb_u2_ctrl.sv
/*
 * Directed testbench for the dsp_clk control slice.
 * Covers misc registers, the LED source mux, the VITA timekeeper
 * with immediate and PPS loads, and the readback words.
 */

`timescale 1ns/100ps
`include "u2_cfg.svh"

module tb_u2_ctrl;

   import u2_pkg::*;

   localparam int          CLK_PERIOD   = 100;
   localparam int          RESET_CYCLES = 10;
   localparam logic [31:0] TPS          = 32'd1000;
   localparam logic [31:0] LFSR_SEED    = 32'hb462af4d;
   localparam logic [31:0] LFSR_TAPS    = 32'h80200003;
   localparam rb_word_t    COMPAT_EXP   = {16'd7, 16'd3};
   localparam int          PPS_WAIT_MAX = 8;
   // Rough cycle counts of the six tests
   localparam int          TEST_CYCLES  = 1 + 11 + 32 + 12 + 23 + 8;
   localparam int          WATCHDOG_CYC = 2 * (RESET_CYCLES + TEST_CYCLES) + 50;

   logic       dsp_clk;
   logic       rst_i;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       run_tx_i;
   logic       run_rx_i;
   logic       clk_status_i;
   logic       link_up_i;
   logic [3:0] serdes_ctrl_o;
   logic [3:0] adc_ctrl_o;
   logic       phy_reset_n_o;
   ctrl_byte_t leds_o;
   logic       pps_i;
   vita_time_t vita_time_o;
   logic       pps_int_o;
   logic       rb_stb_i;
   rb_addr_t   rb_addr_i;
   rb_word_t   status_i;
   rb_word_t   rb_data_o;
   logic       rb_ack_o;

   logic [31:0] lfsr;
   int          cyc = 0;
   int          err_cnt = 0;
   int          last_wr_cyc;
   // Reference time, valid just after edge ref_cyc
   vita_time_t  ref_time;
   int          ref_cyc;

   u2_ctrl_top #(.TICKS_PER_SEC(TPS)) UUT (.*);

   initial dsp_clk = 1'b0;
   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) cyc <= cyc + 1;

   //////////////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Ticks wrap at TPS and carry into seconds
   function automatic vita_time_t time_after(input vita_time_t t, input logic [31:0] n);
      logic [31:0] total;
      total = t[31:0] + n;
      return {t[63:32] + total / TPS, total % TPS};
   endfunction

   function automatic vita_time_t expected_time(input int edge_num);
      return time_after(ref_time, 32'(edge_num - ref_cyc));
   endfunction

   function automatic ctrl_byte_t hw_vector(input logic [3:0] hw);
      return {3'b000, hw, 1'b0};
   endfunction

   function automatic ctrl_byte_t led_expect(input ctrl_byte_t src, input ctrl_byte_t sw,
                                             input ctrl_byte_t hw);
      ctrl_byte_t e;
      for (int i = 0; i < 8; i++) begin
         e[i] = src[i] ? hw[i] : sw[i];
      end
      return e;
   endfunction

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic value_error(input string msg);
      err_cnt++;
      $display("[FAIL] %0d ns: %s", $time, msg);
      abort_run();
   endtask

   task automatic check_word(input string what, input rb_word_t got, input rb_word_t exp);
      assert (got === exp)
      else value_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   task automatic tick();
      @(posedge dsp_clk);
      #10;
   endtask

   task automatic write_reg(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      tick();
      set_stb_i   = 1'b0;
      last_wr_cyc = cyc;
   endtask

   // Returns the word and the edge at which the mux sampled it
   task automatic read_word(input rb_addr_t addr, output rb_word_t data, output int smp);
      rb_stb_i  = 1'b1;
      rb_addr_i = addr;
      tick();
      rb_stb_i = 1'b0;
      smp      = cyc;
      assert (rb_ack_o === 1'b1) else value_error("no readback ack after the strobe");
      data = rb_data_o;
      tick();
      assert (rb_ack_o === 1'b0) else value_error("readback ack longer than one cycle");
   endtask

   task automatic check_time_read(output rb_word_t hi, output rb_word_t lo);
      int         c;
      vita_time_t exp;
      read_word(`RB_TIME_HI, hi, c);
      exp = expected_time(c - 1);
      check_word("time seconds", hi, exp[63:32]);
      read_word(`RB_TIME_LO, lo, c);
      exp = expected_time(c - 1);
      assert (lo < TPS) else value_error("ticks not below TICKS_PER_SEC");
      check_word("time ticks", lo, exp[31:0]);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests

   task automatic test_reset_values();
      tick();
      check_word("leds at reset", 32'(leds_o),
                 32'(led_expect(8'b0001_1110, 8'h00, hw_vector(4'hf))));
      check_word("serdes at reset", 32'(serdes_ctrl_o), 32'd0);
      check_word("adc at reset", 32'(adc_ctrl_o), 32'd0);
      check_word("phy reset_n at reset", 32'(phy_reset_n_o), 32'd1);
      assert (vita_time_o === expected_time(cyc))
      else value_error($sformatf("time after reset is %h", vita_time_o));
   endtask

   task automatic test_misc_writes();
      ctrl_byte_t ser;
      ctrl_byte_t adc;
      ctrl_byte_t leds_before;
      ser = 8'(rand_bits(8));
      adc = 8'(rand_bits(8));
      write_reg(`SR_MISC + 8'd1, 32'(ser));
      tick();
      check_word("serdes ctrl", 32'(serdes_ctrl_o), 32'(ser[3:0]));
      write_reg(`SR_MISC + 8'd2, 32'(adc));
      tick();
      check_word("adc ctrl", 32'(adc_ctrl_o), 32'(adc[3:0]));
      write_reg(`SR_MISC + 8'd4, 32'd1);
      tick();
      check_word("phy reset_n set", 32'(phy_reset_n_o), 32'd0);
      write_reg(`SR_MISC + 8'd4, 32'd0);
      tick();
      check_word("phy reset_n clear", 32'(phy_reset_n_o), 32'd1);
      // Offsets 5 and 8 hold no register
      leds_before = leds_o;
      write_reg(`SR_MISC + 8'd5, rand_bits(32));
      write_reg(`SR_MISC + 8'd8, rand_bits(32));
      tick();
      check_word("serdes after unused write", 32'(serdes_ctrl_o), 32'(ser[3:0]));
      check_word("adc after unused write", 32'(adc_ctrl_o), 32'(adc[3:0]));
      check_word("phy after unused write", 32'(phy_reset_n_o), 32'd1);
      check_word("leds after unused write", 32'(leds_o), 32'(leds_before));
   endtask

   task automatic test_led_mux();
      ctrl_byte_t sw;
      ctrl_byte_t src;
      logic [3:0] hw;
      for (int k = 0; k < 8; k++) begin
         sw  = 8'(rand_bits(8));
         src = 8'(rand_bits(8));
         hw  = 4'(rand_bits(4));
         write_reg(`SR_MISC + 8'd3, 32'(sw));
         write_reg(`SR_MISC + 8'd6, 32'(src));
         {run_tx_i, run_rx_i, clk_status_i, link_up_i} = hw;
         tick();
         tick();
         check_word("leds", 32'(leds_o), 32'(led_expect(src, sw, hw_vector(hw))));
      end
   endtask

   task automatic test_immediate_load();
      logic [31:0] secs;
      rb_word_t    hi0;
      rb_word_t    lo0;
      rb_word_t    hi1;
      rb_word_t    lo1;
      secs = rand_bits(32);
      write_reg(`SR_TIME64 + 8'd0, secs);
      write_reg(`SR_TIME64 + 8'd2, 32'd0);
      write_reg(`SR_TIME64 + 8'd1, 32'd998);
      // Load lands one edge after the ticks register updates
      ref_time = {secs, 32'd998};
      ref_cyc  = last_wr_cyc + 1;
      tick();
      check_time_read(hi0, lo0);
      check_time_read(hi1, lo1);
      check_word("seconds before wrap", hi0, secs);
      check_word("seconds after wrap", hi1, secs + 32'd1);
   endtask

   task automatic test_pps_load();
      logic [31:0] secs;
      logic [31:0] ticks;
      rb_word_t    hi;
      rb_word_t    lo;
      vita_time_t  old_time;
      int          wait_cnt;
      int          c;
      secs  = rand_bits(32);
      ticks = 32'd100 + rand_bits(9);
      write_reg(`SR_TIME64 + 8'd0, secs);
      write_reg(`SR_TIME64 + 8'd2, 32'd1);
      write_reg(`SR_TIME64 + 8'd1, ticks);
      tick();
      // Armed load must wait for the PPS edge
      check_time_read(hi, lo);
      pps_i    = 1'b1;
      wait_cnt = 0;
      while (pps_int_o !== 1'b1) begin
         if (wait_cnt == PPS_WAIT_MAX) begin
            $display("The PPS interrupt never came after the PPS input went high");
            abort_run();
         end
         tick();
         wait_cnt++;
      end
      old_time = expected_time(cyc);
      ref_time = {secs, ticks};
      ref_cyc  = cyc + 1;
      pps_i    = 1'b0;
      tick();
      check_word("pps interrupt width", 32'(pps_int_o), 32'd0);
      read_word(`RB_PPS_HI, hi, c);
      check_word("pps seconds", hi, old_time[63:32]);
      read_word(`RB_PPS_LO, lo, c);
      check_word("pps ticks", lo, old_time[31:0]);
      check_time_read(hi, lo);
      check_word("seconds after pps load", hi, secs);
   endtask

   task automatic test_readback_words();
      rb_word_t d;
      rb_word_t st;
      int       c;
      read_word(`RB_COMPAT, d, c);
      check_word("compat word", d, COMPAT_EXP);
      st       = rand_bits(32);
      status_i = st;
      read_word(`RB_STATUS, d, c);
      check_word("status word", d, st);
      read_word(4'd3, d, c);
      check_word("unused word 3", d, 32'd0);
      read_word(4'd9, d, c);
      check_word("unused word 9", d, 32'd0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial begin
      rst_i        = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      run_tx_i     = 1'b1;
      run_rx_i     = 1'b1;
      clk_status_i = 1'b1;
      link_up_i    = 1'b1;
      pps_i        = 1'b0;
      rb_stb_i     = 1'b0;
      rb_addr_i    = '0;
      status_i     = '0;
      lfsr         = LFSR_SEED;
      ref_time     = '0;
      ref_cyc      = 0;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      #10;
      rst_i   = 1'b0;
      ref_cyc = cyc;
      test_reset_values();
      test_misc_writes();
      test_led_mux();
      test_immediate_load();
      test_pps_load();
      test_readback_words();
      if (err_cnt == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         abort_run();
      end
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      abort_run();
   end

endmodule

//--- logic/u2_ctrl_top.sv
/*
 * Control slice of the radio core on dsp_clk.
 * Board control registers, VITA timekeeper and readback.
 */

`timescale 1ns/100ps
`include "u2_cfg.svh"

module u2_ctrl_top #(
   parameter logic [31:0] TICKS_PER_SEC = `TICKS_PER_SEC_DEFAULT
) (
   input  logic               dsp_clk,
   input  logic               rst_i,

   // Settings bus
   input  logic               set_stb_i,
   input  u2_pkg::set_addr_t  set_addr_i,
   input  u2_pkg::set_data_t  set_data_i,

   // LED hardware status
   input  logic               run_tx_i,
   input  logic               run_rx_i,
   input  logic               clk_status_i,
   input  logic               link_up_i,

   // Board control
   output logic [3:0]         serdes_ctrl_o,
   output logic [3:0]         adc_ctrl_o,
   output logic               phy_reset_n_o,
   output u2_pkg::ctrl_byte_t leds_o,

   // Timing
   input  logic               pps_i,
   output u2_pkg::vita_time_t vita_time_o,
   output logic               pps_int_o,

   // Readback
   input  logic               rb_stb_i,
   input  u2_pkg::rb_addr_t   rb_addr_i,
   input  u2_pkg::rb_word_t   status_i,
   output u2_pkg::rb_word_t   rb_data_o,
   output logic               rb_ack_o
);

   import u2_pkg::*;

   vita_time_t vita_time_pps;

   //////////////////////////////////////////////////////////////////////
   // Board control

   misc_ctrl misc_ctrl (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   //////////////////////////////////////////////////////////////////////
   // VITA time

   time_64bit #(.TICKS_PER_SEC(TICKS_PER_SEC)) time_64bit (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i),
      .vita_time_o(vita_time_o), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o));

   //////////////////////////////////////////////////////////////////////
   // Readback

   readback_mux readback_mux (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .rb_stb_i(rb_stb_i), .rb_addr_i(rb_addr_i),
      .status_i(status_i),
      .vita_time_i(vita_time_o), .vita_time_pps_i(vita_time_pps),
      .rb_data_o(rb_data_o), .rb_ack_o(rb_ack_o));

endmodule

//--- logic/readback_mux.sv
/*
 * Registered readback of status and time words.
 * One of sixteen words is returned a cycle after the strobe.
 */

`timescale 1ns/100ps
`include "u2_cfg.svh"

module readback_mux (
   input  logic               dsp_clk,
   input  logic               rst_i,
   input  logic               rb_stb_i,
   input  u2_pkg::rb_addr_t   rb_addr_i,
   input  u2_pkg::rb_word_t   status_i,
   input  u2_pkg::vita_time_t vita_time_i,
   input  u2_pkg::vita_time_t vita_time_pps_i,
   output u2_pkg::rb_word_t   rb_data_o,
   output logic               rb_ack_o
);

   import u2_pkg::*;

   // Major in the upper half, minor in the lower
   localparam rb_word_t COMPAT_WORD = {`COMPAT_MAJOR, `COMPAT_MINOR};

   rb_word_t word_sel;

   always_comb begin
      case (rb_addr_i)
         `RB_STATUS:  word_sel = status_i;
         `RB_TIME_HI: word_sel = vita_time_i[63:32];
         `RB_TIME_LO: word_sel = vita_time_i[31:0];
         `RB_COMPAT:  word_sel = COMPAT_WORD;
         `RB_PPS_HI:  word_sel = vita_time_pps_i[63:32];
         `RB_PPS_LO:  word_sel = vita_time_pps_i[31:0];
         default:     word_sel = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

   // Data holds until the next strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= word_sel;
      end
   end

   a_ack_follows_stb: assert property (
      @(posedge dsp_clk) disable iff (rst_i) rb_ack_o |-> $past(rb_stb_i)
   );

endmodule

//--- timekeeper/time_64bit.sv
/*
 * VITA 64-bit timekeeper.
 * Counts seconds and ticks, captures the time on each PPS edge
 * and loads a new time either at once or on the next PPS edge.
 */

`timescale 1ns/100ps
`include "u2_cfg.svh"

module time_64bit #(
   parameter logic [31:0] TICKS_PER_SEC = `TICKS_PER_SEC_DEFAULT
) (
   input  logic               dsp_clk,
   input  logic               rst_i,
   input  logic               set_stb_i,
   input  u2_pkg::set_addr_t  set_addr_i,
   input  u2_pkg::set_data_t  set_data_i,
   input  logic               pps_i,
   output u2_pkg::vita_time_t vita_time_o,
   output u2_pkg::vita_time_t vita_time_pps_o,
   output logic               pps_int_o
);

   import u2_pkg::*;

   set_data_t secs_q;
   set_data_t ticks_q;
   set_data_t pend_secs;
   set_data_t pend_ticks;
   logic      ticks_wr;
   logic      pps_mode;
   logic      load_armed;
   logic      do_load;
   logic      pps_s1;
   logic      pps_s2;
   logic      pps_s3;

   //////////////////////////////////////////////////////////////////////
   // Time registers

   // Seconds must be written before ticks
   setting_reg #(.MY_ADDR(`SR_TIME64 + 8'd0), .payload_t(set_data_t)) sr_secs (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(pend_secs), .changed_o());

   // A ticks write arms the load
   setting_reg #(.MY_ADDR(`SR_TIME64 + 8'd1), .payload_t(set_data_t)) sr_ticks (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(pend_ticks), .changed_o(ticks_wr));

   setting_reg #(.MY_ADDR(`SR_TIME64 + 8'd2), .payload_t(logic)) sr_mode (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(pps_mode), .changed_o());

   //////////////////////////////////////////////////////////////////////
   // PPS synchronizer and edge detect

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_s1    <= 1'b0;
         pps_s2    <= 1'b0;
         pps_s3    <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_s3    <= pps_s2;
         pps_int_o <= pps_s2 & ~pps_s3;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Counter and loads

   // Immediate mode loads on the ticks write, PPS mode waits for the edge
   assign do_load = (ticks_wr & ~pps_mode) | (load_armed & pps_int_o);

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         load_armed <= 1'b0;
      end else if (ticks_wr) begin
         load_armed <= pps_mode;
      end else if (pps_int_o) begin
         load_armed <= 1'b0;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         secs_q  <= '0;
         ticks_q <= '0;
      end else if (do_load) begin
         secs_q  <= pend_secs;
         ticks_q <= pend_ticks;
      end else if (ticks_q == TICKS_PER_SEC - 32'd1) begin
         secs_q  <= secs_q + 32'd1;
         ticks_q <= '0;
      end else begin
         ticks_q <= ticks_q + 32'd1;
      end
   end

   assign vita_time_o = {secs_q, ticks_q};

   // Time as it stood before this cycle's update
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         vita_time_pps_o <= '0;
      end else if (pps_int_o) begin
         vita_time_pps_o <= vita_time_o;
      end
   end

   a_ticks_range: assert property (
      @(posedge dsp_clk) disable iff (rst_i) ticks_q < TICKS_PER_SEC
   );

   a_pps_single: assert property (
      @(posedge dsp_clk) disable iff (rst_i) pps_int_o |=> !pps_int_o
   );

endmodule

//--- logic/misc_ctrl.sv
/*
 * Board control registers on the settings bus.
 * Drives SERDES and ADC control lines, PHY reset and the LEDs,
 * with a per-bit choice of hardware status or software value.
 */

`timescale 1ns/100ps
`include "u2_cfg.svh"

module misc_ctrl (
   input  logic               dsp_clk,
   input  logic               rst_i,
   input  logic               set_stb_i,
   input  u2_pkg::set_addr_t  set_addr_i,
   input  u2_pkg::set_data_t  set_data_i,
   input  logic               run_tx_i,
   input  logic               run_rx_i,
   input  logic               clk_status_i,
   input  logic               link_up_i,
   output logic [3:0]         serdes_ctrl_o,
   output logic [3:0]         adc_ctrl_o,
   output logic               phy_reset_n_o,
   output u2_pkg::ctrl_byte_t leds_o
);

   import u2_pkg::*;

   ctrl_byte_t serdes_q;
   ctrl_byte_t adc_q;
   ctrl_byte_t led_sw;
   ctrl_byte_t led_src;
   ctrl_byte_t led_hw;
   logic       phy_reset;

   //////////////////////////////////////////////////////////////////////
   // Control registers

   setting_reg #(.MY_ADDR(`SR_MISC + 8'd1), .payload_t(ctrl_byte_t)) sr_ser (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(serdes_q), .changed_o());

   setting_reg #(.MY_ADDR(`SR_MISC + 8'd2), .payload_t(ctrl_byte_t)) sr_adc (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(adc_q), .changed_o());

   setting_reg #(.MY_ADDR(`SR_MISC + 8'd3), .payload_t(ctrl_byte_t)) sr_led (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_sw), .changed_o());

   setting_reg #(
      .MY_ADDR(`SR_MISC + 8'd6),
      .payload_t(ctrl_byte_t),
      .AT_RESET(`LED_SRC_AT_RESET)
   ) sr_led_src (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_src), .changed_o());

   // PHY held in reset while this bit is set
   setting_reg #(.MY_ADDR(`SR_MISC + 8'd4), .payload_t(logic)) sr_phy (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(phy_reset), .changed_o());

   assign serdes_ctrl_o = serdes_q[3:0];
   assign adc_ctrl_o    = adc_q[3:0];
   assign phy_reset_n_o = ~phy_reset;

   //////////////////////////////////////////////////////////////////////
   // LEDs

   // Bit 0 and the top three bits have no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         leds_o <= '0;
      end else begin
         leds_o <= (led_src & led_hw) | (~led_src & led_sw);
      end
   end

endmodule

//--- logic/setting_reg.sv
/*
 * Single settings bus register.
 * Latches the low payload bits of the data on an address match
 * and flags the update with a one-cycle changed pulse.
 */

`timescale 1ns/100ps

module setting_reg #(
   parameter u2_pkg::set_addr_t MY_ADDR  = '0,
   parameter type               payload_t = logic [31:0],
   parameter payload_t          AT_RESET = '0
) (
   input  logic              dsp_clk,
   input  logic              rst_i,
   input  logic              set_stb_i,
   input  u2_pkg::set_addr_t set_addr_i,
   input  u2_pkg::set_data_t set_data_i,
   output payload_t          value_o,
   output logic              changed_o
);

   logic hit;

   // Strobe aimed at this register
   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         value_o   <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            value_o <= payload_t'(set_data_i[$bits(payload_t)-1:0]);
         end
      end
   end

   // Back-to-back changed pulses need back-to-back matching strobes
   a_changed_needs_hit: assert property (
      @(posedge dsp_clk) disable iff (rst_i)
      (changed_o && $past(changed_o)) |-> $past(hit)
   );

endmodule

//--- common/u2_pkg.sv
/*
 * Shared types for the radio core control slice.
 * Covers the settings bus, VITA time, control bytes and readback.
 */

package u2_pkg;

   //////////////////////////////////////////////////////////////////////
   // Settings bus

   // Register address on the settings bus
   typedef logic [7:0]  set_addr_t;

   // Write data on the settings bus
   typedef logic [31:0] set_data_t;

   //////////////////////////////////////////////////////////////////////
   // Time and control

   // Seconds in [63:32], ticks within the second in [31:0]
   typedef logic [63:0] vita_time_t;

   // SERDES, ADC, LED and LED source registers
   typedef logic [7:0]  ctrl_byte_t;

   //////////////////////////////////////////////////////////////////////
   // Readback

   typedef logic [31:0] rb_word_t;

   // Word index into the sixteen readback words
   typedef logic [3:0]  rb_addr_t;

endpackage

//--- common/u2_cfg.svh
/*
 * Control slice configuration.
 * Settings bus bases, compatibility number, reset values
 * and readback word indices.
 */

`ifndef U2_CFG_SVH
`define U2_CFG_SVH

// Settings register bases
`define SR_MISC                8'd0
`define SR_TIME64              8'd10

// Bump when the FPGA changes enough to matter to host software
`define COMPAT_MAJOR           16'd7
`define COMPAT_MINOR           16'd3

// LEDs 1 to 4 under hardware control out of reset
`define LED_SRC_AT_RESET       8'b0001_1110

// 100 MHz sample clock
`define TICKS_PER_SEC_DEFAULT  32'd100000000

// Readback word indices
`define RB_STATUS              4'd8
`define RB_TIME_HI             4'd10
`define RB_TIME_LO             4'd11
`define RB_COMPAT              4'd12
`define RB_PPS_HI              4'd14
`define RB_PPS_LO              4'd15

`endif
